//--- periph_hub.f
source/periph_hub_pkg.sv
source/periph_req_if.sv
source/periph_decode.sv
source/gpio_block.sv
source/read_return.sv
source/periph_hub_top.sv
tests/tb_clk_gen.sv
tests/tb_periph_hub.sv

//--- Makefile
TOP := tb_periph_hub
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): periph_hub.f source/*.sv tests/*.sv
	verilator --binary --timing --assert -f periph_hub.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	verilator --lint-only -Wall source/periph_hub_pkg.sv source/periph_req_if.sv \
		source/periph_decode.sv source/gpio_block.sv source/read_return.sv \
		source/periph_hub_top.sv --top-module periph_hub_top

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tb_periph_hub.sv
/*
 * Testbench for the peripheral hub: stimulus table with expected values
 * from a GPIO register model, row loop, compare tasks and cycle timeout
 */
`timescale 1ns/1ps

module tb_periph_hub;
    import periph_hub_pkg::*;

    localparam func_sel_t RESET_SEL = 5'd2;
    localparam func_sel_t GPIO_SEL = 5'h01;

    typedef struct {
        logic         is_write;
        bus_size_e    size;
        periph_addr_t addr;
        bus_word_t    wdata;
        pin_vec_t     ui_in;
        bus_word_t    exp_word;
        pin_vec_t     exp_pins;
        logic         complete;
    } row_t;

    logic clk;
    logic rst_n;
    pin_vec_t ui_in;
    pin_vec_t uo_out;
    periph_addr_t addr;
    bus_word_t data_in;
    bus_size_e write_size;
    bus_size_e read_size;
    bus_word_t data_out;
    logic data_ready;
    logic read_complete;

    row_t rows[$];
    integer seed = 79;
    int num_rows = 0;
    int cycle_count = 0;
    int word_errors = 0;
    int pin_errors = 0;
    int ready_errors = 0;

    // Register model of the GPIO slot and the read hold
    pin_vec_t model_out;
    func_sel_t model_fsel [NUM_PINS];
    logic model_hold;
    bus_word_t model_held;

    tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(8)) u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

    periph_hub_top #(.RESET_SEL_LOW_PINS(RESET_SEL)) DUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .i_addr               (addr),
        .i_data_in            (data_in),
        .i_data_write_n       (write_size),
        .i_data_read_n        (read_size),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .i_data_read_complete (read_complete)
    );

    // GPIO slot is user slot 1, anything else is empty
    function automatic logic gpio_addressed(input periph_addr_t a);
        return !a[10] && (a[9:6] == SLOT_GPIO);
    endfunction

    function automatic logic fsel_offset(input logic [5:0] ofs);
        return (ofs >= GPIO_FSEL_BASE) && (ofs[1:0] == 2'b00);
    endfunction

    function automatic bus_word_t model_read(input periph_addr_t a, input pin_vec_t pins);
        if (!gpio_addressed(a)) return '0;
        if (a[5:0] == GPIO_OFS_OUT) return {24'h0, model_out};
        if (a[5:0] == GPIO_OFS_IN) return {24'h0, pins};
        if (fsel_offset(a[5:0])) return {27'h0, model_fsel[a[4:2]]};
        return '0;
    endfunction

    // Only the low byte of the write data reaches a GPIO register
    task automatic model_write(input periph_addr_t a, input bus_word_t d);
        if (gpio_addressed(a)) begin
            if (a[5:0] == GPIO_OFS_OUT) model_out = d[7:0];
            if (fsel_offset(a[5:0])) model_fsel[a[4:2]] = d[4:0];
        end
    endtask

    function automatic pin_vec_t model_pins();
        pin_vec_t p;
        for (int i = 0; i < NUM_PINS; i++) begin
            p[i] = (model_fsel[i] == GPIO_SEL) ? model_out[i] : 1'b0;
        end
        return p;
    endfunction

    task automatic add_row(input logic is_write, input bus_size_e size, input periph_addr_t a,
                           input bus_word_t d, input logic complete);
        row_t r;
        integer rnd;
        rnd = $random(seed);
        r.is_write = is_write;
        r.size = size;
        r.addr = a;
        r.wdata = d;
        r.ui_in = rnd[7:0];
        r.complete = complete;
        r.exp_word = '0;
        if (is_write) begin
            model_write(a, d);
        end else begin
            // A read while holding returns the word already captured
            if (!model_hold) begin
                model_held = model_read(a, r.ui_in);
                model_hold = 1'b1;
            end
            r.exp_word = model_held;
            if (complete) model_hold = 1'b0;
        end
        r.exp_pins = model_pins();
        rows.push_back(r);
    endtask

    task automatic build_table();
        model_out = '0;
        model_hold = 1'b0;
        model_held = '0;
        for (int i = 0; i < NUM_PINS; i++) model_fsel[i] = (i < 2) ? RESET_SEL : GPIO_SEL;
        add_row(0, SIZE_WORD, 11'h060, 32'h0, 1);
        add_row(0, SIZE_WORD, 11'h074, 32'h0, 1);
        add_row(1, SIZE_BYTE, 11'h040, 32'h0000_00a5, 0);
        add_row(0, SIZE_WORD, 11'h040, 32'h0, 1);
        add_row(1, SIZE_BYTE, 11'h060, 32'h0000_0001, 0);
        add_row(1, SIZE_BYTE, 11'h060, 32'h0000_0010, 0);
        add_row(1, SIZE_BYTE, 11'h06c, 32'h0000_0004, 0);
        add_row(0, SIZE_WORD, 11'h044, 32'h0, 1);
        add_row(0, SIZE_WORD, 11'h048, 32'h0, 1);
        add_row(0, SIZE_WORD, 11'h080, 32'h0, 1);
        add_row(0, SIZE_BYTE, 11'h400, 32'h0, 1);
        // Simple slot 4 shares bits 9:6 with the GPIO user slot
        add_row(0, SIZE_HALF, 11'h440, 32'h0, 1);
        // Hold: second read before complete returns the first word
        add_row(0, SIZE_WORD, 11'h040, 32'h0, 0);
        add_row(0, SIZE_WORD, 11'h044, 32'h0, 1);
        add_row(0, SIZE_WORD, 11'h044, 32'h0, 1);
        add_row(1, SIZE_HALF, 11'h040, 32'h1234_5678, 0);
        add_row(1, SIZE_WORD, 11'h064, 32'hffff_ff01, 0);
        add_row(0, SIZE_WORD, 11'h064, 32'h0, 1);
        add_row(1, SIZE_WORD, 11'h080, 32'h0000_00ff, 0);
        add_row(1, SIZE_WORD, 11'h040, 32'hdead_be3c, 0);
        add_row(0, SIZE_WORD, 11'h040, 32'h0, 1);
    endtask

    task automatic check_word(input int row, input bus_word_t got, input bus_word_t exp);
        if (got !== exp) begin
            word_errors++;
            $display("[FAIL] %0d ns: row %0d read data 0x%08h, expected 0x%08h",
                     $time, row, got, exp);
        end
    endtask

    task automatic check_pins(input int row, input pin_vec_t got, input pin_vec_t exp);
        if (got !== exp) begin
            pin_errors++;
            $display("[FAIL] %0d ns: row %0d output pins 0x%02h, expected 0x%02h",
                     $time, row, got, exp);
        end
    endtask

    task automatic check_ready(input int row, input logic got, input logic exp);
        if (got !== exp) begin
            ready_errors++;
            $display("[FAIL] %0d ns: row %0d data ready %b, expected %b", $time, row, got, exp);
        end
    endtask

    // Entered 1 ns after a rising edge, leaves at the same point of a later cycle
    task automatic apply_row(input row_t r, input int idx);
        addr = r.addr;
        data_in = r.wdata;
        ui_in = r.ui_in;
        if (r.is_write) begin
            write_size = r.size;
            #4;
            check_ready(idx, data_ready, 1'b1);
            @(posedge clk);
            #1;
            write_size = SIZE_NONE;
        end else begin
            read_size = r.size;
            @(posedge clk);
            #4;
            check_ready(idx, data_ready, 1'b1);
            check_word(idx, data_out, r.exp_word);
            @(posedge clk);
            #1;
            read_size = SIZE_NONE;
            read_complete = r.complete;
            @(posedge clk);
            #1;
            read_complete = 1'b0;
        end
        @(posedge clk);
        #4;
        check_pins(idx, uo_out, r.exp_pins);
        check_ready(idx, data_ready, 1'b0);
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 20 * num_rows + 50) begin
            $display("Timeout: test did not finish within %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        ui_in = '0;
        addr = '0;
        data_in = '0;
        write_size = SIZE_NONE;
        read_size = SIZE_NONE;
        read_complete = 1'b0;
        build_table();
        num_rows = rows.size();
        wait (rst_n === 1'b1);
        // Idle after reset: no ready, all pins low
        @(posedge clk);
        #4;
        check_ready(-1, data_ready, 1'b0);
        check_pins(-1, uo_out, '0);
        @(posedge clk);
        #1;
        for (int i = 0; i < num_rows; i++) apply_row(rows[i], i);
        total = word_errors + pin_errors + ready_errors;
        $display("Errors: read data %0d, pins %0d, ready %0d, total %0d",
                 word_errors, pin_errors, ready_errors, total);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- tests/tb_clk_gen.sv
/*
 * Testbench clock and synchronous reset generator
 */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release just after an edge so the synchronous reset sees a clean level
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

//--- source/periph_hub_top.sv
/*
 * Peripheral hub top level: decoder, GPIO block and read return stage
 */
`timescale 1ns/1ps

module periph_hub_top #(
    parameter periph_hub_pkg::func_sel_t RESET_SEL_LOW_PINS = 5'd2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  periph_hub_pkg::pin_vec_t     i_ui_in,
    output periph_hub_pkg::pin_vec_t     o_uo_out,
    input  periph_hub_pkg::periph_addr_t i_addr,
    input  periph_hub_pkg::bus_word_t    i_data_in,
    input  periph_hub_pkg::bus_size_e    i_data_write_n,
    input  periph_hub_pkg::bus_size_e    i_data_read_n,
    output periph_hub_pkg::bus_word_t    o_data_out,
    output logic                         o_data_ready,
    input  logic                         i_data_read_complete
);
    import periph_hub_pkg::*;

    bus_word_t peri_data;
    logic read_req;
    logic write_req;

    periph_req_if req_if ();

    periph_decode u_decode (
        .i_addr       (i_addr),
        .i_data_in    (i_data_in),
        .i_write_size (i_data_write_n),
        .i_read_size  (i_data_read_n),
        .req          (req_if.decoder),
        .o_peri_data  (peri_data),
        .o_read_req   (read_req),
        .o_write_req  (write_req)
    );

    gpio_block #(
        .RESET_SEL_LOW_PINS (RESET_SEL_LOW_PINS)
    ) u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req_if.gpio),
        .i_ui_in  (i_ui_in),
        .o_uo_out (o_uo_out)
    );

    read_return u_read_return (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_peri_data          (peri_data),
        .i_read_req           (read_req),
        .i_write_req          (write_req),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

endmodule

//--- source/read_return.sv
/*
 * Read data capture and hold until the core completes the read,
 * and data ready generation for reads and writes
 */
`timescale 1ns/1ps

module read_return (
    input  logic                      clk,
    input  logic                      rst_n,
    input  periph_hub_pkg::bus_word_t i_peri_data,
    input  logic                      i_read_req,
    input  logic                      i_write_req,
    input  logic                      i_data_read_complete,
    output periph_hub_pkg::bus_word_t o_data_out,
    output logic                      o_data_ready
);
    import periph_hub_pkg::*;

    bus_word_t data_r;
    logic hold;
    logic read_ready_r;
    logic capture;

    // First read cycle while nothing is held
    assign capture = i_read_req && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold <= 1'b0;
            read_ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            // Ready rises one cycle after the read request
            read_ready_r <= i_read_req;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_peri_data;
        end
    end

    assign o_data_out = data_r;
    // Writes are acknowledged in their own cycle
    assign o_data_ready = read_ready_r || i_write_req;

    assert property (@(posedge clk) disable iff (!rst_n)
        (hold && !i_data_read_complete) |=> $stable(data_r))
        else $error("Held read data changed before read complete");

endmodule

//--- source/gpio_block.sv
/*
 * GPIO registers: output byte, input pin view and eight function selects,
 * plus routing of the output pins by function select
 */
`timescale 1ns/1ps

module gpio_block #(
    parameter periph_hub_pkg::func_sel_t RESET_SEL_LOW_PINS = 5'd2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    periph_req_if.gpio               req,
    input  periph_hub_pkg::pin_vec_t i_ui_in,
    output periph_hub_pkg::pin_vec_t o_uo_out
);
    import periph_hub_pkg::*;

    localparam int PIN_IDX_W = $clog2(NUM_PINS);

    // Select value that routes a pin to the GPIO output register
    localparam func_sel_t GPIO_SEL = {SLOT_USER, SLOT_GPIO};

    pin_vec_t gpio_out;
    func_sel_t [NUM_PINS-1:0] func_sel;

    logic fsel_hit;
    logic [PIN_IDX_W-1:0] fsel_idx;

    // Function select words sit at 0x20, 0x24 .. 0x3c
    assign fsel_hit = (req.offset >= GPIO_FSEL_BASE) && (req.offset[1:0] == 2'b00);
    assign fsel_idx = req.offset[PIN_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int i = 0; i < NUM_PINS; i++) begin
                // Pins 0 and 1 start on an empty slot
                if (i < 2) begin
                    func_sel[i] <= RESET_SEL_LOW_PINS;
                end else begin
                    func_sel[i] <= GPIO_SEL;
                end
            end
        end else if (req.gpio_wr) begin
            if (req.offset == GPIO_OFS_OUT) begin
                gpio_out <= req.wdata;
            end
            if (fsel_hit) begin
                func_sel[fsel_idx] <= func_sel_t'(req.wdata[4:0]);
            end
        end
    end

    // Register read, zero for unused offsets
    always_comb begin
        if (req.offset == GPIO_OFS_OUT) begin
            req.rdata = bus_word_t'(gpio_out);
        end else if (req.offset == GPIO_OFS_IN) begin
            req.rdata = bus_word_t'(i_ui_in);
        end else if (fsel_hit) begin
            req.rdata = bus_word_t'(func_sel[fsel_idx]);
        end else begin
            req.rdata = '0;
        end
    end

    // Only the GPIO slot drives pins, every other selection gives zero
    always_comb begin
        for (int i = 0; i < NUM_PINS; i++) begin
            o_uo_out[i] = (func_sel[i] == GPIO_SEL) ? gpio_out[i] : 1'b0;
        end
    end

    // Pin routing only moves through a decoded GPIO write
    assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$past(req.gpio_wr)) |-> $stable(func_sel))
        else $error("Function select changed without a GPIO write");

endmodule

//--- source/periph_decode.sv
/*
 * Address decode into user and simple slots, GPIO write qualification
 * and read data selection
 */
`timescale 1ns/1ps

module periph_decode (
    input  periph_hub_pkg::periph_addr_t i_addr,
    input  periph_hub_pkg::bus_word_t    i_data_in,
    input  periph_hub_pkg::bus_size_e    i_write_size,
    input  periph_hub_pkg::bus_size_e    i_read_size,
    periph_req_if.decoder                req,
    output periph_hub_pkg::bus_word_t    o_peri_data,
    output logic                         o_read_req,
    output logic                         o_write_req
);
    import periph_hub_pkg::*;

    slot_kind_e slot_kind;
    logic [3:0] slot_idx;

    // Bit 10 set means a 16 byte simple slot, else a 64 byte user slot
    always_comb begin
        slot_kind = slot_kind_e'(i_addr[ADDR_W-1]);
        if (slot_kind == SLOT_SIMPLE) begin
            slot_idx = i_addr[7:4];
        end else begin
            slot_idx = i_addr[9:6];
        end
    end

    assign o_read_req = (i_read_size != SIZE_NONE);
    assign o_write_req = (i_write_size != SIZE_NONE);

    assign req.offset = i_addr[5:0];
    assign req.wdata = i_data_in[7:0];
    assign req.gpio_sel = (slot_kind == SLOT_USER) && (slot_idx == SLOT_GPIO);
    // Any write size updates only the low byte of a GPIO register
    assign req.gpio_wr = req.gpio_sel && o_write_req;

    // All other slots are empty and read as zero
    assign o_peri_data = req.gpio_sel ? req.rdata : '0;

    // A GPIO write only ever targets user slot 1 of the raw address
    always_comb begin
        if (req.gpio_wr) begin
            assert #0 ((i_addr[ADDR_W-1:6] == {1'b0, SLOT_GPIO}) && (i_write_size != SIZE_NONE))
                else $error("GPIO write outside the GPIO slot");
        end
    end

endmodule

//--- source/periph_req_if.sv
/*
 * Decoded access from the address decoder to the GPIO register block
 */
`timescale 1ns/1ps

interface periph_req_if;
    import periph_hub_pkg::*;

    // Address within the slot
    logic [5:0] offset;
    // Low byte of the write data
    logic [7:0] wdata;
    logic gpio_sel;
    logic gpio_wr;
    // Register value at offset, returned by the GPIO block
    bus_word_t rdata;

    modport decoder (
        output offset,
        output wdata,
        output gpio_sel,
        output gpio_wr,
        input  rdata
    );

    modport gpio (
        input  offset,
        input  wdata,
        input  gpio_wr,
        output rdata
    );

endinterface

//--- source/periph_hub_pkg.sv
/*
 * Shared definitions for the peripheral hub: bus widths and types,
 * access size and slot kind enums, GPIO slot index and register offsets
 */
package periph_hub_pkg;

    // Peripheral address and data widths
    localparam int ADDR_W = 11;
    localparam int NUM_PINS = 8;

    typedef logic [ADDR_W-1:0] periph_addr_t;
    typedef logic [31:0] bus_word_t;
    typedef logic [NUM_PINS-1:0] pin_vec_t;

    // Access size as driven by the core, 3 means no access
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_NONE = 2'd3
    } bus_size_e;

    // Address bit 10 and the top bit of a function select pick the slot kind
    typedef enum logic {
        SLOT_USER   = 1'b0,
        SLOT_SIMPLE = 1'b1
    } slot_kind_e;

    // Top bit is the slot kind, low 4 bits the slot index
    typedef logic [4:0] func_sel_t;

    // User slot that holds the GPIO registers
    localparam logic [3:0] SLOT_GPIO = 4'd1;

    // GPIO register offsets within the 64 byte slot
    localparam logic [5:0] GPIO_OFS_OUT = 6'h00;
    localparam logic [5:0] GPIO_OFS_IN = 6'h04;

    // One word per pin from here up to 0x3c
    localparam logic [5:0] GPIO_FSEL_BASE = 6'h20;

endpackage
